// File: vlog.f
source/axi_ctrl_pkg.sv
source/req_fifo.sv
source/request_arbiter.sv
source/addr_decoder.sv
source/mailbox_regs.sv
source/stream_sender.sv
source/axi_ctrl_top.sv
verif/axi_ctrl_tb.sv

// File: Bender.yml
package:
  name: axi_ctrl

sources:
  - source/axi_ctrl_pkg.sv
  - source/req_fifo.sv
  - source/request_arbiter.sv
  - source/addr_decoder.sv
  - source/mailbox_regs.sv
  - source/stream_sender.sv
  - source/axi_ctrl_top.sv
  - target: test
    files:
      - verif/axi_ctrl_tb.sv

// File: verif/axi_ctrl_tb.sv
// -------------------
// table-driven testbench for the request-routing top level
// builds a stimulus table from a small register model, then applies it
// one entry at a time while a monitor checks every DUT output strobe
// -------------------
`timescale 1ns/1ps
`default_nettype none

module axi_ctrl_tb;

    import axi_ctrl_pkg::*;

    localparam logic [1:0] K_LS_WR   = 2'd0;
    localparam logic [1:0] K_LS_RD   = 2'd1;
    localparam logic [1:0] K_SS_PAIR = 2'd2;
    localparam logic [1:0] K_RD_SS   = 2'd3;

    typedef struct packed {
        logic [1:0]  kind;
        logic [27:0] addr;
        logic [31:0] data;
        logic [3:0]  strb;
        logic [1:0]  n_rdone;
        logic [31:0] rdata;
        logic [31:0] rdata_alt;
        logic [1:0]  n_beats;
        logic [31:0] beat0;
        logic [1:0]  user0;
        logic [31:0] beat1;
        logic [1:0]  user1;
        logic        irq;
    } entry_t;

    logic axi_aclk, axi_aresetn, axi_interrupt;
    logic bk_ls_wstart, bk_ls_rstart, bk_ls_rdone;
    logic bk_sm_start, bk_ss_valid, bk_ss_ready;
    ls_addr_t bk_ls_waddr, bk_ls_raddr;
    data_t bk_ls_wdata, bk_ls_rdata, bk_sm_data, bk_ss_data;
    strb_t bk_ls_wstrb;
    user_t bk_sm_user, bk_ss_user;

    entry_t table_q [$];
    entry_t cur;
    int     rdone_seen, beats_seen, irq_seen;
    int     cycle_count, cycle_limit;
    // register model used while the table is built
    data_t  mb_model [8];
    logic   en_model, st_model;

    axi_ctrl_top #(.FIFO_DEPTH(8)) dut_i (.*);

    initial axi_aclk = 1'b0;
    always #2 axi_aclk = ~axi_aclk;

    // -------------------
    // failure reporting
    task automatic stop_run();
        $display("SIMULATION FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic mismatch_error(input string msg);
        $display("FAILED at %0t ns: %s", $time, msg);
        stop_run();
    endtask

    task automatic protocol_error(input string msg);
        $display("error at %0t ns: %s", $time, msg);
        stop_run();
    endtask

    function automatic bit in_range(input logic [27:0] a, input logic [27:0] lo,
                                    input logic [27:0] hi);
        return (a >= lo) && (a <= hi);
    endfunction

    function automatic bit in_user(input logic [27:0] a);
        return in_range(a, USER_WIN0_LOW, USER_WIN0_HIGH) ||
               in_range(a, USER_WIN1_LOW, USER_WIN1_HIGH);
    endfunction

    // -------------------
    // table builders, expected values follow the address map rules
    task automatic add_ls_write(input logic [27:0] addr, input data_t data, input strb_t strb);
        entry_t e;
        e = '0;
        e.kind = K_LS_WR;
        e.addr = addr;
        e.data = data;
        e.strb = strb;
        if (in_range(addr, MB_LOW, MB_HIGH)) begin
            mb_model[addr[4:2]] = data;
        end else if (in_range(addr, AA_LOW, AA_HIGH)) begin
            if (!addr[2]) begin
                en_model = data[0];
            end else if (data[0]) begin
                st_model = 1'b0;
            end
        end else if (in_user(addr)) begin
            e.n_beats = 2'd2;
            e.beat0   = {strb, addr};
            e.user0   = 2'd1;
            e.beat1   = data;
            e.user1   = 2'd1;
        end
        table_q.push_back(e);
    endtask

    task automatic add_ls_read(input logic [27:0] addr);
        entry_t e;
        e = '0;
        e.kind = K_LS_RD;
        e.addr = addr;
        e.n_rdone = 2'd1;
        if (in_range(addr, MB_LOW, MB_HIGH)) begin
            e.rdata = mb_model[addr[4:2]];
        end else if (in_range(addr, AA_LOW, AA_HIGH)) begin
            e.rdata = {31'b0, addr[2] ? st_model : en_model};
        end else if (in_range(addr, MB_LOW, LOCAL_HIGH)) begin
            e.rdata = 32'hFFFF_FFFF;
        end else begin
            e.n_rdone = 2'd0;
            if (in_user(addr)) begin
                e.n_beats = 2'd1;
                e.beat0   = {4'b0, addr};
                e.user0   = 2'd2;
            end
        end
        e.rdata_alt = e.rdata;
        table_q.push_back(e);
    endtask

    // remote mailbox write, optionally with an LS read of the same word in the same cycle
    task automatic add_ss_pair(input logic [27:0] addr, input data_t data, input bit with_read);
        entry_t e;
        e = '0;
        e.kind = with_read ? K_RD_SS : K_SS_PAIR;
        e.addr = addr;
        e.data = data;
        e.strb = 4'hF;
        if (with_read) begin
            e.n_rdone = 2'd1;
            e.rdata   = mb_model[addr[4:2]];
        end
        if (in_range(addr, MB_LOW, MB_HIGH)) begin
            mb_model[addr[4:2]] = data;
            e.irq = en_model;
            if (en_model) begin
                st_model = 1'b1;
            end
        end
        e.rdata_alt = mb_model[addr[4:2]];
        table_q.push_back(e);
    endtask

    task automatic build_table();
        for (int i = 0; i < 8; i++) begin
            add_ls_write(28'h2000 + 4 * i, $urandom, 4'hF);
        end
        for (int i = 0; i < 8; i++) begin
            add_ls_read(28'h2000 + 4 * i);
        end
        add_ls_write(28'h2100, 32'hFFFF_FFFF, 4'hF);
        add_ls_read(28'h2100);
        add_ls_read(28'h2108);
        add_ls_read(28'h2FFC);
        add_ls_write(28'h2200, $urandom, 4'hF);
        add_ls_read(28'h2200);
        add_ls_read(28'h2000);
        add_ls_write(28'h0010, $urandom, 4'hA);
        add_ls_write(28'h3004, $urandom, 4'h3);
        add_ls_read(28'h0010);
        add_ls_read(28'h3004);
        add_ls_write(28'h5000, $urandom, 4'hF);
        add_ls_read(28'h5000);
        add_ss_pair(28'h200C, $urandom, 1'b0);
        add_ls_read(28'h200C);
        add_ls_read(28'h2104);
        add_ls_write(28'h2104, 32'h1, 4'hF);
        add_ls_read(28'h2104);
        add_ls_write(28'h2100, 32'h0, 4'hF);
        add_ss_pair(28'h200C, $urandom, 1'b0);
        add_ls_read(28'h200C);
        add_ls_read(28'h2104);
        add_ss_pair(28'h200C, $urandom, 1'b1);
        // the competing pair must have landed as well
        add_ls_read(28'h200C);
    endtask

    // -------------------
    // apply one entry and wait for its outputs
    task automatic run_entry(input entry_t e);
        bit ss_kind;
        ss_kind = (e.kind == K_SS_PAIR) || (e.kind == K_RD_SS);
        @(posedge axi_aclk);
        #1;
        cur        = e;
        rdone_seen = 0;
        beats_seen = 0;
        irq_seen   = 0;
        if (e.kind == K_LS_WR) begin
            bk_ls_wstart = 1'b1;
            bk_ls_waddr  = e.addr[14:0];
            bk_ls_wdata  = e.data;
            bk_ls_wstrb  = e.strb;
        end
        if (e.kind == K_LS_RD || e.kind == K_RD_SS) begin
            bk_ls_rstart = 1'b1;
            bk_ls_raddr  = e.addr[14:0];
        end
        if (ss_kind) begin
            assert (bk_ss_ready) else protocol_error("stream slave not ready for first beat");
            bk_ss_valid = 1'b1;
            bk_ss_data  = {e.strb, e.addr};
            bk_ss_user  = 2'd1;
        end
        @(posedge axi_aclk);
        #1;
        bk_ls_wstart = 1'b0;
        bk_ls_rstart = 1'b0;
        if (ss_kind) begin
            assert (bk_ss_ready) else protocol_error("stream slave not ready for second beat");
            bk_ss_data = e.data;
            @(posedge axi_aclk);
            #1;
            bk_ss_valid = 1'b0;
        end
        if (e.n_rdone != 0 || e.n_beats != 0 || e.irq) begin
            while (rdone_seen != e.n_rdone || beats_seen != e.n_beats || irq_seen != e.irq) begin
                @(negedge axi_aclk);
            end
            repeat (8) @(posedge axi_aclk);
        end else begin
            repeat (20) @(posedge axi_aclk);
        end
    endtask

    // -------------------
    // output monitor, sampled mid-cycle
    always @(negedge axi_aclk) begin
        if (axi_aresetn && bk_ls_rdone) begin
            assert (rdone_seen < cur.n_rdone) else protocol_error("unexpected bk_ls_rdone");
            assert (bk_ls_rdata == cur.rdata || bk_ls_rdata == cur.rdata_alt)
                else mismatch_error($sformatf("rdata %h, expected %h", bk_ls_rdata, cur.rdata));
            rdone_seen++;
        end
        if (axi_aresetn && bk_sm_start) begin
            assert (beats_seen < cur.n_beats) else protocol_error("unexpected bk_sm_start");
            assert (bk_sm_data == (beats_seen == 0 ? cur.beat0 : cur.beat1) &&
                    bk_sm_user == (beats_seen == 0 ? cur.user0 : cur.user1))
                else mismatch_error($sformatf("beat %0d data %h user %0d wrong",
                                              beats_seen, bk_sm_data, bk_sm_user));
            beats_seen++;
        end
        if (axi_aresetn && axi_interrupt) begin
            assert (irq_seen < cur.irq) else protocol_error("unexpected interrupt pulse");
            irq_seen++;
        end
    end

    always @(posedge axi_aclk) begin
        cycle_count++;
        if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            stop_run();
        end
    end

    initial begin
        axi_aresetn  = 1'b0;
        bk_ls_wstart = 1'b0;
        bk_ls_waddr  = '0;
        bk_ls_wdata  = '0;
        bk_ls_wstrb  = '0;
        bk_ls_rstart = 1'b0;
        bk_ls_raddr  = '0;
        bk_ss_data   = '0;
        bk_ss_user   = '0;
        bk_ss_valid  = 1'b0;
        cur          = '0;
        cycle_count  = 0;
        cycle_limit  = 0;
        en_model     = 1'b0;
        st_model     = 1'b0;
        void'($urandom(32'h720a));
        build_table();
        cycle_limit = table_q.size() * 40 + 100;
        repeat (4) @(posedge axi_aclk);
        #1;
        axi_aresetn = 1'b1;
        assert (bk_ss_ready && !axi_interrupt && !bk_ls_rdone && !bk_sm_start)
            else mismatch_error("outputs not at their reset values");
        for (int i = 0; i < table_q.size(); i++) begin
            run_entry(table_q[i]);
        end
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: source/axi_ctrl_top.sv
// -------------------
// request-routing top: arbiter, decoder, registers and sender in a row
// -------------------
`timescale 1ns/1ps
`default_nettype none

module axi_ctrl_top #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic                   axi_aclk,
    input  logic                   axi_aresetn,
    output logic                   axi_interrupt,
    // axi-lite slave side
    input  logic                   bk_ls_wstart,
    input  axi_ctrl_pkg::ls_addr_t bk_ls_waddr,
    input  axi_ctrl_pkg::data_t    bk_ls_wdata,
    input  axi_ctrl_pkg::strb_t    bk_ls_wstrb,
    input  logic                   bk_ls_rstart,
    input  axi_ctrl_pkg::ls_addr_t bk_ls_raddr,
    output axi_ctrl_pkg::data_t    bk_ls_rdata,
    output logic                   bk_ls_rdone,
    // stream master side
    output logic                   bk_sm_start,
    output axi_ctrl_pkg::data_t    bk_sm_data,
    output axi_ctrl_pkg::user_t    bk_sm_user,
    // stream slave side
    input  axi_ctrl_pkg::data_t    bk_ss_data,
    input  axi_ctrl_pkg::user_t    bk_ss_user,
    input  logic                   bk_ss_valid,
    output logic                   bk_ss_ready
);

    import axi_ctrl_pkg::*;

    logic       req_valid, req_read;
    src_t       req_src;
    req_addr_t  req_addr;
    data_t      req_data;
    strb_t      req_strb;
    logic       op_valid;
    op_kind_t   op_kind;
    logic [2:0] op_index;
    req_addr_t  op_addr;
    data_t      op_data;
    strb_t      op_strb;
    logic       res_valid;
    res_kind_t  res_kind;
    req_addr_t  res_addr;
    data_t      res_data;
    strb_t      res_strb;

    request_arbiter #(.FIFO_DEPTH(FIFO_DEPTH)) arbiter_i (
        .axi_aclk, .axi_aresetn,
        .bk_ls_wstart, .bk_ls_waddr, .bk_ls_wdata, .bk_ls_wstrb,
        .bk_ls_rstart, .bk_ls_raddr,
        .bk_ss_data, .bk_ss_user, .bk_ss_valid, .bk_ss_ready,
        .req_valid, .req_src, .req_read, .req_addr, .req_data, .req_strb
    );

    addr_decoder decoder_i (
        .axi_aclk, .axi_aresetn,
        .req_valid, .req_src, .req_read, .req_addr, .req_data, .req_strb,
        .op_valid, .op_kind, .op_index, .op_addr, .op_data, .op_strb
    );

    mailbox_regs regs_i (
        .axi_aclk, .axi_aresetn,
        .op_valid, .op_kind, .op_index, .op_addr, .op_data, .op_strb,
        .res_valid, .res_kind, .res_addr, .res_data, .res_strb, .axi_interrupt
    );

    stream_sender sender_i (
        .axi_aclk, .axi_aresetn,
        .res_valid, .res_kind, .res_addr, .res_data, .res_strb,
        .bk_ls_rdata, .bk_ls_rdone, .bk_sm_start, .bk_sm_data, .bk_sm_user
    );

endmodule

`default_nettype wire

// File: source/stream_sender.sv
// -------------------
// drives LS read returns and stream master beats from results
// a forward write takes two consecutive beats
// -------------------
`timescale 1ns/1ps
`default_nettype none

module stream_sender (
    input  logic                    axi_aclk,
    input  logic                    axi_aresetn,
    input  logic                    res_valid,
    input  axi_ctrl_pkg::res_kind_t res_kind,
    input  axi_ctrl_pkg::req_addr_t res_addr,
    input  axi_ctrl_pkg::data_t     res_data,
    input  axi_ctrl_pkg::strb_t     res_strb,
    output axi_ctrl_pkg::data_t     bk_ls_rdata,
    output logic                    bk_ls_rdone,
    output logic                    bk_sm_start,
    output axi_ctrl_pkg::data_t     bk_sm_data,
    output axi_ctrl_pkg::user_t     bk_sm_user
);

    import axi_ctrl_pkg::*;

    logic  wr_second;
    data_t wr_data_q;

    always_ff @(posedge axi_aclk or negedge axi_aresetn) begin
        if (!axi_aresetn) begin
            bk_ls_rdone <= 1'b0;
            bk_sm_start <= 1'b0;
            wr_second   <= 1'b0;
        end else begin
            bk_ls_rdone <= res_valid && (res_kind == RES_LS_RDATA);
            bk_sm_start <= wr_second || (res_valid && (res_kind != RES_LS_RDATA));
            wr_second   <= res_valid && (res_kind == RES_SM_FWD_WR);
        end
    end

    always_ff @(posedge axi_aclk) begin
        if (wr_second) begin
            bk_sm_data <= wr_data_q;
            bk_sm_user <= SS_USER_WRITE;
        end else if (res_valid) begin
            case (res_kind)
                RES_SM_FWD_WR: begin
                    // strobe on top, address below
                    bk_sm_data <= {res_strb, res_addr};
                    bk_sm_user <= SS_USER_WRITE;
                    wr_data_q  <= res_data;
                end
                RES_SM_FWD_RD: begin
                    bk_sm_data <= {4'b0, res_addr};
                    bk_sm_user <= SM_USER_READ;
                end
                default: bk_ls_rdata <= res_data;
            endcase
        end
    end

    // arbiter spacing keeps the second write beat free
    a_no_overlap: assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
        wr_second |-> !res_valid);

endmodule

`default_nettype wire

// File: source/mailbox_regs.sv
// -------------------
// mailbox and access-control registers, executes decoded operations
// pulses axi_interrupt on an enabled remote mailbox write
// -------------------
`timescale 1ns/1ps
`default_nettype none

module mailbox_regs (
    input  logic                     axi_aclk,
    input  logic                     axi_aresetn,
    input  logic                     op_valid,
    input  axi_ctrl_pkg::op_kind_t   op_kind,
    input  logic [2:0]               op_index,
    input  axi_ctrl_pkg::req_addr_t  op_addr,
    input  axi_ctrl_pkg::data_t      op_data,
    input  axi_ctrl_pkg::strb_t      op_strb,
    output logic                     res_valid,
    output axi_ctrl_pkg::res_kind_t  res_kind,
    output axi_ctrl_pkg::req_addr_t  res_addr,
    output axi_ctrl_pkg::data_t      res_data,
    output axi_ctrl_pkg::strb_t      res_strb,
    output logic                     axi_interrupt
);

    import axi_ctrl_pkg::*;

    data_t     mb_q [MB_WORDS];
    logic      int_en;
    logic      int_status;
    data_t     rd_word;
    res_kind_t kind_d;
    logic      has_result;

    always_comb begin
        rd_word    = op_data;
        kind_d     = RES_LS_RDATA;
        has_result = 1'b1;
        case (op_kind)
            OP_MB_RD:     rd_word = mb_q[op_index];
            // only bit 0 of each AA word exists
            OP_AA_RD:     rd_word = {31'b0, (op_index == 3'd0) ? int_en : int_status};
            OP_UNSUPP_RD: rd_word = UNSUPP_DATA;
            OP_FWD_WR:    kind_d  = RES_SM_FWD_WR;
            OP_FWD_RD:    kind_d  = RES_SM_FWD_RD;
            default:      has_result = 1'b0;
        endcase
    end

    always_ff @(posedge axi_aclk or negedge axi_aresetn) begin
        if (!axi_aresetn) begin
            int_en        <= 1'b0;
            int_status    <= 1'b0;
            res_valid     <= 1'b0;
            axi_interrupt <= 1'b0;
        end else begin
            res_valid     <= op_valid && has_result;
            axi_interrupt <= op_valid && (op_kind == OP_REMOTE_MB_WR) && int_en;
            if (op_valid && op_kind == OP_AA_WR) begin
                if (op_index == 3'd0) begin
                    int_en <= op_data[0];
                end else if (op_data[0]) begin
                    // status is write-one-to-clear
                    int_status <= 1'b0;
                end
            end else if (op_valid && op_kind == OP_REMOTE_MB_WR && int_en) begin
                int_status <= 1'b1;
            end
        end
    end

    always_ff @(posedge axi_aclk) begin
        if (op_valid && (op_kind == OP_MB_WR || op_kind == OP_REMOTE_MB_WR)) begin
            mb_q[op_index] <= op_data;
        end
        if (op_valid) begin
            res_kind <= kind_d;
            res_addr <= op_addr;
            res_data <= rd_word;
            res_strb <= op_strb;
        end
    end

    // decoder and register file must agree on the index ranges
    a_mb_index: assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
        op_valid && (op_kind inside {OP_MB_WR, OP_MB_RD, OP_REMOTE_MB_WR})
        |-> (op_addr >= MB_LOW) && (int'((op_addr - MB_LOW) >> 2) < MB_WORDS)
            && (op_index == op_addr[4:2]));
    a_aa_index: assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
        op_valid && (op_kind inside {OP_AA_WR, OP_AA_RD}) |-> (op_index <= 3'd1));

endmodule

`default_nettype wire

// File: source/addr_decoder.sv
// -------------------
// registered decode of a request into an operation and word index
// -------------------
`timescale 1ns/1ps
`default_nettype none

module addr_decoder (
    input  logic                    axi_aclk,
    input  logic                    axi_aresetn,
    input  logic                    req_valid,
    input  axi_ctrl_pkg::src_t      req_src,
    input  logic                    req_read,
    input  axi_ctrl_pkg::req_addr_t req_addr,
    input  axi_ctrl_pkg::data_t     req_data,
    input  axi_ctrl_pkg::strb_t     req_strb,
    output logic                    op_valid,
    output axi_ctrl_pkg::op_kind_t  op_kind,
    output logic [2:0]              op_index,
    output axi_ctrl_pkg::req_addr_t op_addr,
    output axi_ctrl_pkg::data_t     op_data,
    output axi_ctrl_pkg::strb_t     op_strb
);

    import axi_ctrl_pkg::*;

    op_kind_t   kind;
    logic [2:0] index;
    req_addr_t  mb_off, aa_off;
    logic       in_mb, in_aa, in_local, in_user;

    assign mb_off   = req_addr - MB_LOW;
    assign aa_off   = req_addr - AA_LOW;
    assign in_mb    = (req_addr >= MB_LOW) && (req_addr <= MB_HIGH);
    assign in_aa    = (req_addr >= AA_LOW) && (req_addr <= AA_HIGH);
    assign in_local = (req_addr >= MB_LOW) && (req_addr <= LOCAL_HIGH);
    assign in_user  = ((req_addr >= USER_WIN0_LOW) && (req_addr <= USER_WIN0_HIGH)) ||
                      ((req_addr >= USER_WIN1_LOW) && (req_addr <= USER_WIN1_HIGH));

    always_comb begin
        kind  = OP_DROP;
        index = mb_off[4:2];
        if (req_src == SRC_LS) begin
            if (in_mb) begin
                kind = req_read ? OP_MB_RD : OP_MB_WR;
            end else if (in_aa) begin
                kind  = req_read ? OP_AA_RD : OP_AA_WR;
                index = aa_off[4:2];
            end else if (in_local) begin
                // rest of the local range, writes are ignored
                kind = req_read ? OP_UNSUPP_RD : OP_DROP;
            end else if (in_user) begin
                kind = req_read ? OP_FWD_RD : OP_FWD_WR;
            end
        end else if (in_mb) begin
            kind = OP_REMOTE_MB_WR;
        end
    end

    always_ff @(posedge axi_aclk or negedge axi_aresetn) begin
        if (!axi_aresetn) begin
            op_valid <= 1'b0;
        end else begin
            op_valid <= req_valid;
        end
    end

    always_ff @(posedge axi_aclk) begin
        if (req_valid) begin
            op_kind  <= kind;
            op_index <= index;
            op_addr  <= req_addr;
            op_data  <= req_data;
            op_strb  <= req_strb;
        end
    end

endmodule

`default_nettype wire

// File: source/request_arbiter.sv
// -------------------
// queues LS and SS requests and issues them round-robin, one every two cycles
// SS write beats are paired here before issue
// -------------------
`timescale 1ns/1ps
`default_nettype none

module request_arbiter #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic                    axi_aclk,
    input  logic                    axi_aresetn,
    input  logic                    bk_ls_wstart,
    input  axi_ctrl_pkg::ls_addr_t  bk_ls_waddr,
    input  axi_ctrl_pkg::data_t     bk_ls_wdata,
    input  axi_ctrl_pkg::strb_t     bk_ls_wstrb,
    input  logic                    bk_ls_rstart,
    input  axi_ctrl_pkg::ls_addr_t  bk_ls_raddr,
    input  axi_ctrl_pkg::data_t     bk_ss_data,
    input  axi_ctrl_pkg::user_t     bk_ss_user,
    input  logic                    bk_ss_valid,
    output logic                    bk_ss_ready,
    output logic                    req_valid,
    output axi_ctrl_pkg::src_t      req_src,
    output logic                    req_read,
    output axi_ctrl_pkg::req_addr_t req_addr,
    output axi_ctrl_pkg::data_t     req_data,
    output axi_ctrl_pkg::strb_t     req_strb
);

    import axi_ctrl_pkg::*;

    ls_req_t  ls_wr_data;
    ls_req_t  ls_rd_data;
    ss_beat_t ss_rd_data;
    logic     ls_empty, ss_empty, ss_full;
    logic     ls_pop, ss_pop, pick_ss;
    logic     pair_pending;
    data_t    first_beat;
    src_t     last_src;

    // write wins if both strobes show up
    always_comb begin
        ls_wr_data = '0;
        if (bk_ls_wstart) begin
            ls_wr_data.addr = bk_ls_waddr;
            ls_wr_data.data = bk_ls_wdata;
            ls_wr_data.strb = bk_ls_wstrb;
        end else begin
            ls_wr_data.read = 1'b1;
            ls_wr_data.addr = bk_ls_raddr;
        end
    end

    req_fifo #(.payload_t(ls_req_t), .FIFO_DEPTH(FIFO_DEPTH)) ls_fifo_i (
        .axi_aclk, .axi_aresetn,
        .wr_en(bk_ls_wstart | bk_ls_rstart), .wr_data(ls_wr_data),
        .rd_en(ls_pop), .rd_data(ls_rd_data), .full(), .empty(ls_empty)
    );

    req_fifo #(.payload_t(ss_beat_t), .FIFO_DEPTH(FIFO_DEPTH)) ss_fifo_i (
        .axi_aclk, .axi_aresetn,
        .wr_en(bk_ss_valid & bk_ss_ready), .wr_data('{data: bk_ss_data, user: bk_ss_user}),
        .rd_en(ss_pop), .rd_data(ss_rd_data), .full(ss_full), .empty(ss_empty)
    );

    assign bk_ss_ready = !ss_full;

    // -------------------
    // selection, a pending pair only waits for its second beat
    assign pick_ss = pair_pending ? !ss_empty
                                  : (!ss_empty && (ls_empty || last_src == SRC_LS));
    assign ss_pop  = !req_valid && pick_ss;
    assign ls_pop  = !req_valid && !pair_pending && !pick_ss && !ls_empty;

    always_ff @(posedge axi_aclk or negedge axi_aresetn) begin
        if (!axi_aresetn) begin
            req_valid    <= 1'b0;
            pair_pending <= 1'b0;
            last_src     <= SRC_LS;
        end else begin
            req_valid <= ls_pop || (ss_pop && pair_pending);
            if (ls_pop) begin
                last_src <= SRC_LS;
            end else if (ss_pop) begin
                last_src <= SRC_SS;
            end
            // beats with other user codes are dropped here
            if (ss_pop) begin
                pair_pending <= !pair_pending && (ss_rd_data.user == SS_USER_WRITE);
            end
        end
    end

    always_ff @(posedge axi_aclk) begin
        if (ss_pop && !pair_pending) begin
            first_beat <= ss_rd_data.data;
        end
        if (ls_pop) begin
            req_src  <= SRC_LS;
            req_read <= ls_rd_data.read;
            req_addr <= req_addr_t'(ls_rd_data.addr);
            req_data <= ls_rd_data.data;
            req_strb <= ls_rd_data.strb;
        end else if (ss_pop && pair_pending) begin
            // first beat holds strobe and address
            req_src  <= SRC_SS;
            req_read <= 1'b0;
            req_addr <= first_beat[27:0];
            req_data <= ss_rd_data.data;
            req_strb <= first_beat[31:28];
        end
    end

    a_ls_one_strobe: assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
        !(bk_ls_wstart && bk_ls_rstart));

endmodule

`default_nettype wire

// File: source/req_fifo.sv
// -------------------
// synchronous FIFO with a count, payload set by type parameter
// first word is visible on rd_data while not empty
// -------------------
`timescale 1ns/1ps
`default_nettype none

module req_fifo #(
    parameter type payload_t  = logic,
    parameter int  FIFO_DEPTH = 8
) (
    input  logic     axi_aclk,
    input  logic     axi_aresetn,
    input  logic     wr_en,
    input  payload_t wr_data,
    input  logic     rd_en,
    output payload_t rd_data,
    output logic     full,
    output logic     empty
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    payload_t         mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    assign full    = (count == CNT_W'(FIFO_DEPTH));
    assign empty   = (count == '0);
    assign rd_data = mem[rd_ptr];

    always_ff @(posedge axi_aclk or negedge axi_aresetn) begin
        if (!axi_aresetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CNT_W'(wr_en) - CNT_W'(rd_en);
        end
    end

    always_ff @(posedge axi_aclk) begin
        if (wr_en) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // producer and consumer must respect full and empty
    a_no_overflow: assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
        !(wr_en && full));
    a_no_underflow: assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
        !(rd_en && empty));

endmodule

`default_nettype wire

// File: source/axi_ctrl_pkg.sv
// -------------------
// types, address map and codes shared by the request-routing pipeline
// modules import it with axi_ctrl_pkg::* inside their body
// -------------------
`default_nettype none

package axi_ctrl_pkg;

    typedef logic [31:0] data_t;
    typedef logic [3:0]  strb_t;
    typedef logic [1:0]  user_t;
    typedef logic [14:0] ls_addr_t;
    // wide enough for stream addresses, LS addresses are zero-extended
    typedef logic [27:0] req_addr_t;

    // -------------------
    // local address map, byte addresses
    localparam req_addr_t MB_LOW         = 28'h000_2000;
    localparam req_addr_t MB_HIGH        = 28'h000_201F;
    localparam req_addr_t AA_LOW         = 28'h000_2100;
    localparam req_addr_t AA_HIGH        = 28'h000_2107;
    localparam req_addr_t LOCAL_HIGH     = 28'h000_2FFF;
    // user project windows, forwarded to the stream master
    localparam req_addr_t USER_WIN0_LOW  = 28'h000_0000;
    localparam req_addr_t USER_WIN0_HIGH = 28'h000_1FFF;
    localparam req_addr_t USER_WIN1_LOW  = 28'h000_3000;
    localparam req_addr_t USER_WIN1_HIGH = 28'h000_4FFF;

    localparam int    MB_WORDS    = 8;
    localparam data_t UNSUPP_DATA = 32'hFFFF_FFFF;

    // stream user codes
    localparam user_t SS_USER_WRITE = 2'd1;
    localparam user_t SM_USER_READ  = 2'd2;

    // -------------------
    // FIFO payloads, a read carries zero data and strobe
    typedef struct packed {
        logic     read;
        ls_addr_t addr;
        data_t    data;
        strb_t    strb;
    } ls_req_t;

    typedef struct packed {
        data_t data;
        user_t user;
    } ss_beat_t;

    typedef enum logic {SRC_LS, SRC_SS} src_t;

    typedef enum logic [3:0] {
        OP_MB_WR, OP_MB_RD, OP_AA_WR, OP_AA_RD, OP_UNSUPP_RD,
        OP_FWD_WR, OP_FWD_RD, OP_REMOTE_MB_WR, OP_DROP
    } op_kind_t;

    typedef enum logic [1:0] {RES_LS_RDATA, RES_SM_FWD_WR, RES_SM_FWD_RD} res_kind_t;

endpackage

`default_nettype wire
